//--- hw/dram_write_latch.sv
`timescale 1ns/10ps
`include "scpad_settings.svh"

module dram_write_latch (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       spill_valid,
    input  scpad_pkg::row_t            row_data,
    input  scpad_pkg::dram_addr_t      base_addr,
    input  scpad_pkg::beat_cnt_t       num_beats,
    input  logic                       be_stall,
    output scpad_pkg::dram_write_req_t dram_req,
    output logic                       latched
);

    // beat index bits and byte offset bits of the address
    localparam int idx_bits  = $clog2(`SCPAD_BEATS_PER_ROW);
    localparam int off_bits  = $clog2(`SCPAD_BEAT_BITS / 8);
    localparam int keep_lsb  = idx_bits + off_bits;

    scpad_pkg::dram_write_req_t req_q;
    scpad_pkg::dram_write_req_t nxt_req;

    scpad_pkg::beat_cnt_t count;
    scpad_pkg::beat_cnt_t nxt_count;

    logic [idx_bits-1:0]   beat_idx;
    scpad_pkg::beat_t      beat_data;
    scpad_pkg::dram_addr_t beat_addr;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req_q <= '0;
            count <= '0;
        end else begin
            req_q <= nxt_req;
            count <= nxt_count;
        end
    end

    // slice and address of the beat the counter points at
    assign beat_idx  = count[idx_bits-1:0];
    assign beat_data = row_data[beat_idx * `SCPAD_BEAT_BITS +: `SCPAD_BEAT_BITS];
    assign beat_addr = {base_addr[`SCPAD_DRAM_ADDR_BITS-1:keep_lsb], beat_idx,
                        {off_bits{1'b0}}};

    always_comb begin
        nxt_req   = req_q;
        nxt_count = count;
        latched   = 1'b0;

        // stall freezes counter and request
        if (spill_valid && !be_stall) begin
            if (count < num_beats) begin
                nxt_req.valid     = 1'b1;
                nxt_req.wdata     = beat_data;
                nxt_req.dram_addr = beat_addr;
                nxt_count         = count + 1'b1;
            end else if (count == num_beats) begin
                // last beat is taken this cycle
                latched   = 1'b1;
                nxt_count = '0;
                nxt_req   = '0;
            end
        end
    end

    assign dram_req = req_q;

endmodule

//--- hw/scpad_pkg.sv
`include "scpad_settings.svh"

package scpad_pkg;

    // meaningful widths
    typedef logic [$clog2(`SCPAD_ROWS)-1:0] row_idx_t;
    typedef logic [`SCPAD_ROW_BITS-1:0] row_t;
    typedef logic [`SCPAD_BEAT_BITS-1:0] beat_t;
    typedef logic [`SCPAD_DRAM_ADDR_BITS-1:0] dram_addr_t;

    // one extra bit so the count can reach a full row
    typedef logic [$clog2(`SCPAD_BEATS_PER_ROW):0] beat_cnt_t;

    // num_beats is legal from 1 to a full row
    typedef struct packed {
        row_idx_t   row;
        dram_addr_t base_addr;
        beat_cnt_t  num_beats;
    } spill_cmd_t;

    typedef struct packed {
        logic       valid;
        beat_t      wdata;
        dram_addr_t dram_addr;
    } dram_write_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_spill
    } spill_state_t;

endpackage

//--- hw/scpad_row_buffer.sv
`timescale 1ns/10ps
`include "scpad_settings.svh"

module scpad_row_buffer (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                wr_en,
    input  scpad_pkg::row_idx_t wr_row,
    input  scpad_pkg::row_t     wr_data,
    input  logic                rd_en,
    input  scpad_pkg::row_idx_t rd_row,
    output scpad_pkg::row_t     rd_data
);

    // row storage
    scpad_pkg::row_t rows [`SCPAD_ROWS];

    scpad_pkg::row_t rd_data_q;

    // fill port, takes effect at the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            rows[wr_row] <= wr_data;
        end
    end

    // read port: data shows one cycle after rd_en
    // and stays until the next read
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data_q <= '0;
        end else if (rd_en) begin
            rd_data_q <= rows[rd_row];
        end
    end

    assign rd_data = rd_data_q;

endmodule

//--- hw/scpad_settings.svh
`ifndef SCPAD_SETTINGS_SVH
`define SCPAD_SETTINGS_SVH

// scratchpad geometry
`define SCPAD_ROWS 16
`define SCPAD_ROW_BITS 512

// one DRAM data beat, 8 bytes
`define SCPAD_BEAT_BITS 64

// row bits divided by beat bits
`define SCPAD_BEATS_PER_ROW 8

// DRAM byte address
`define SCPAD_DRAM_ADDR_BITS 32

`endif

//--- hw/scpad_writeback_top.sv
`timescale 1ns/10ps

module scpad_writeback_top (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       fill_en,
    input  scpad_pkg::row_idx_t        fill_row,
    input  scpad_pkg::row_t            fill_data,
    input  logic                       spill_start,
    input  scpad_pkg::spill_cmd_t      spill_cmd,
    input  logic                       be_stall,
    output scpad_pkg::dram_write_req_t dram_req,
    output logic                       spill_busy,
    output logic                       spill_done
);

    // buffer read port
    logic                rd_en;
    scpad_pkg::row_idx_t rd_row;
    scpad_pkg::row_t     rd_data;

    // sequencer to latch
    logic                  spill_valid;
    scpad_pkg::dram_addr_t base_addr;
    scpad_pkg::beat_cnt_t  num_beats;
    logic                  latched;

    scpad_row_buffer u_row_buffer (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (fill_en),
        .wr_row  (fill_row),
        .wr_data (fill_data),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

    spill_sequencer u_spill_sequencer (
        .clk         (clk),
        .n_rst       (n_rst),
        .spill_start (spill_start),
        .spill_cmd   (spill_cmd),
        .latched     (latched),
        .rd_en       (rd_en),
        .rd_row      (rd_row),
        .spill_valid (spill_valid),
        .base_addr   (base_addr),
        .num_beats   (num_beats),
        .busy        (spill_busy)
    );

    dram_write_latch u_dram_write_latch (
        .clk         (clk),
        .n_rst       (n_rst),
        .spill_valid (spill_valid),
        .row_data    (rd_data),
        .base_addr   (base_addr),
        .num_beats   (num_beats),
        .be_stall    (be_stall),
        .dram_req    (dram_req),
        .latched     (latched)
    );

    // done pulse is the latch's latched strobe
    assign spill_done = latched;

endmodule

//--- hw/spill_sequencer.sv
`timescale 1ns/10ps

module spill_sequencer (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  spill_start,
    input  scpad_pkg::spill_cmd_t spill_cmd,
    input  logic                  latched,
    output logic                  rd_en,
    output scpad_pkg::row_idx_t   rd_row,
    output logic                  spill_valid,
    output scpad_pkg::dram_addr_t base_addr,
    output scpad_pkg::beat_cnt_t  num_beats,
    output logic                  busy
);

    scpad_pkg::spill_state_t state;
    scpad_pkg::spill_state_t nxt_state;

    // command held for the whole spill
    scpad_pkg::spill_cmd_t cmd_q;
    scpad_pkg::spill_cmd_t nxt_cmd;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= scpad_pkg::st_idle;
            cmd_q <= '0;
        end else begin
            state <= nxt_state;
            cmd_q <= nxt_cmd;
        end
    end

    always_comb begin
        nxt_state = state;
        nxt_cmd   = cmd_q;

        case (state)
            scpad_pkg::st_idle: begin
                // only idle listens to the start strobe
                if (spill_start) begin
                    nxt_cmd   = spill_cmd;
                    nxt_state = scpad_pkg::st_read;
                end
            end

            scpad_pkg::st_read: begin
                // row data lands in the buffer's read register at this edge
                nxt_state = scpad_pkg::st_spill;
            end

            scpad_pkg::st_spill: begin
                // latch reports the last beat taken
                if (latched) begin
                    nxt_state = scpad_pkg::st_idle;
                end
            end

            default: begin
                nxt_state = scpad_pkg::st_idle;
            end
        endcase
    end

    // single read pulse, ahead of any latch activity
    assign rd_en  = (state == scpad_pkg::st_read);
    assign rd_row = cmd_q.row;

    // valid level for the latch, held until latched
    assign spill_valid = (state == scpad_pkg::st_spill);
    assign base_addr   = cmd_q.base_addr;
    assign num_beats   = cmd_q.num_beats;

    assign busy = (state != scpad_pkg::st_idle);

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the scratchpad write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_scpad_writeback

verilator --binary --timing -Wno-fatal \
    -f scpad_writeback.f \
    --top-module "$top" \
    -o "$top"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/"$top")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi

//--- scpad_writeback.f
+incdir+hw
hw/scpad_pkg.sv
hw/scpad_row_buffer.sv
hw/spill_sequencer.sv
hw/dram_write_latch.sv
hw/scpad_writeback_top.sv
tests/tb_clock_gen.sv
tests/tb_scpad_writeback.sv

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        n_rst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
    end

endmodule

//--- tests/tb_scpad_writeback.sv
`timescale 1ns/10ps
`include "scpad_settings.svh"

module tb_scpad_writeback;

    localparam int clk_period_ns = 40;
    localparam int max_stall     = 4;
    localparam int test_count    = 6;

    // worst case of one spill from start to done, longest stall runs
    localparam int spill_cycles = (`SCPAD_BEATS_PER_ROW + 3) * (max_stall + 1);
    localparam int watchdog_ns  = (test_count * spill_cycles * 4 + 100) * clk_period_ns;

    logic                       clk;
    logic                       n_rst;
    logic                       fill_en;
    scpad_pkg::row_idx_t        fill_row;
    scpad_pkg::row_t            fill_data;
    logic                       spill_start;
    scpad_pkg::spill_cmd_t      spill_cmd;
    logic                       be_stall;
    scpad_pkg::dram_write_req_t dram_req;
    logic                       spill_busy;
    logic                       spill_done;

    // model copy of every filled row
    scpad_pkg::row_t model_rows [`SCPAD_ROWS];

    // beats taken by the collector
    scpad_pkg::beat_t      got_data [$];
    scpad_pkg::dram_addr_t got_addr [$];
    int                    got_cycle [$];

    int   cycle_cnt   = 0;
    int   start_cycle = 0;
    int   done_cnt    = 0;
    int   done_cycle  = 0;
    int   done_before = 0;
    int   stall_hits  = 0;
    int   stall_run   = 0;
    logic stall_en    = 1'b0;
    int   err_cnt     = 0;
    int   check_cnt   = 0;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(10)) u_clock_gen (
        .clk   (clk),
        .n_rst (n_rst)
    );

    scpad_writeback_top DUT (
        .clk         (clk),
        .n_rst       (n_rst),
        .fill_en     (fill_en),
        .fill_row    (fill_row),
        .fill_data   (fill_data),
        .spill_start (spill_start),
        .spill_cmd   (spill_cmd),
        .be_stall    (be_stall),
        .dram_req    (dram_req),
        .spill_busy  (spill_busy),
        .spill_done  (spill_done)
    );

    // a beat is taken on a rising edge with valid high and no stall
    always @(posedge clk) begin
        if (n_rst) begin
            if (dram_req.valid && !be_stall) begin
                got_data.push_back(dram_req.wdata);
                got_addr.push_back(dram_req.dram_addr);
                got_cycle.push_back(cycle_cnt);
            end
            if (spill_busy && be_stall) begin
                stall_hits++;
            end
            if (spill_done) begin
                done_cnt++;
                done_cycle = cycle_cnt;
            end
        end
        cycle_cnt++;
    end

    // random back-end stall, runs capped at max_stall cycles
    initial begin
        be_stall = 1'b0;
        forever begin
            @(negedge clk);
            if (stall_en && stall_run < max_stall && ($urandom % 2 == 1)) begin
                be_stall = 1'b1;
                stall_run++;
            end else begin
                be_stall  = 1'b0;
                stall_run = 0;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("ERROR %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    function automatic scpad_pkg::row_t random_row();
        scpad_pkg::row_t r;
        int              i;
        for (i = 0; i < `SCPAD_ROW_BITS / 32; i++) begin
            r[i*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    // beat i is the i-th 64-bit slice of the row
    function automatic scpad_pkg::beat_t expected_data(input scpad_pkg::row_idx_t row,
                                                       input int idx);
        return model_rows[row][idx*`SCPAD_BEAT_BITS +: `SCPAD_BEAT_BITS];
    endfunction

    // upper base bits kept, beat index in bits 5..3, low bits zero
    function automatic scpad_pkg::dram_addr_t expected_addr(input scpad_pkg::dram_addr_t base,
                                                            input int idx);
        return (base & 32'hffff_ffc0) | (32'(idx) << 3);
    endfunction

    function automatic scpad_pkg::spill_cmd_t make_cmd(input int row, input int num);
        scpad_pkg::spill_cmd_t cmd;
        cmd.row       = scpad_pkg::row_idx_t'(row);
        cmd.base_addr = $urandom;
        cmd.num_beats = scpad_pkg::beat_cnt_t'(num);
        return cmd;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic load_row(input scpad_pkg::row_idx_t idx, input scpad_pkg::row_t data);
        @(negedge clk);
        fill_en   = 1'b1;
        fill_row  = idx;
        fill_data = data;
        model_rows[idx] = data;
        @(negedge clk);
        fill_en = 1'b0;
    endtask

    // called on a falling edge, the next rising edge takes the strobe
    task automatic start_spill(input scpad_pkg::spill_cmd_t cmd);
        got_data.delete();
        got_addr.delete();
        got_cycle.delete();
        stall_hits  = 0;
        done_before = done_cnt;
        start_cycle = cycle_cnt;
        spill_cmd   = cmd;
        spill_start = 1'b1;
        @(negedge clk);
        spill_start = 1'b0;
    endtask

    task automatic wait_spill_done(input string test_name);
        int waited;
        waited = 0;
        while (done_cnt == done_before && waited < spill_cycles * 2) begin
            check_value(test_name, "spill_busy before done", 1, spill_busy);
            @(negedge clk);
            waited++;
        end
        if (done_cnt == done_before) begin
            err_cnt++;
            $display("%s: no done pulse within %0d cycles of the start", test_name, waited);
        end else begin
            check_value(test_name, "spill_busy after done", 0, spill_busy);
        end
    endtask

    task automatic compare_spill(input string test_name, input scpad_pkg::spill_cmd_t cmd);
        int n;
        int i;
        n = (got_data.size() < cmd.num_beats) ? got_data.size() : cmd.num_beats;
        check_value(test_name, "beat count", cmd.num_beats, got_data.size());
        check_value(test_name, "done pulses", 1, done_cnt - done_before);
        for (i = 0; i < n; i++) begin
            check_value(test_name, $sformatf("beat %0d data", i),
                        expected_data(cmd.row, i), got_data[i]);
            check_value(test_name, $sformatf("beat %0d address", i),
                        expected_addr(cmd.base_addr, i), got_addr[i]);
        end
        if (got_cycle.size() > 0) begin
            check_value(test_name, "done cycle", got_cycle[$], done_cycle);
        end
    endtask

    // no stall, first beat 3 cycles after the start
    task automatic check_timing(input string test_name, input int num);
        if (got_cycle.size() > 0) begin
            check_value(test_name, "first beat cycle", start_cycle + 3, got_cycle[0]);
            check_value(test_name, "done cycle", start_cycle + 3 + num - 1, done_cycle);
        end
    endtask

    task automatic test_reset();
        repeat (3) begin
            @(negedge clk);
            check_value("reset", "valid in reset", 0, dram_req.valid);
            check_value("reset", "spill_busy in reset", 0, spill_busy);
            check_value("reset", "spill_done in reset", 0, spill_done);
        end
        wait (n_rst === 1'b1);
        @(negedge clk);
        check_value("reset", "valid after reset", 0, dram_req.valid);
        check_value("reset", "spill_busy after reset", 0, spill_busy);
        check_value("reset", "spill_done after reset", 0, spill_done);
    endtask

    task automatic test_full_spill();
        scpad_pkg::spill_cmd_t cmd;
        cmd = make_cmd(3, 8);
        start_spill(cmd);
        wait_spill_done("full_spill");
        idle(3);
        compare_spill("full_spill", cmd);
        check_timing("full_spill", 8);
    endtask

    task automatic test_partial_spill();
        scpad_pkg::spill_cmd_t cmd;
        cmd = make_cmd(9, 3);
        start_spill(cmd);
        wait_spill_done("partial_spill");
        idle(4);
        compare_spill("partial_spill", cmd);
        check_timing("partial_spill", 3);
    endtask

    task automatic test_random_stall();
        scpad_pkg::spill_cmd_t cmd;
        cmd = make_cmd($urandom % `SCPAD_ROWS, 8);
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        start_spill(cmd);
        wait_spill_done("random_stall");
        check_value("random_stall", "stall seen during spill", 1, stall_hits != 0);
        @(posedge clk);
        stall_en = 1'b0;
        idle(3);
        compare_spill("random_stall", cmd);
    endtask

    task automatic test_start_while_busy();
        scpad_pkg::spill_cmd_t cmd_a;
        scpad_pkg::spill_cmd_t cmd_b;
        cmd_a = make_cmd(5, 8);
        cmd_b = make_cmd(11, 2);
        start_spill(cmd_a);
        idle(3);
        // second command lands mid-spill
        check_value("start_busy", "spill_busy at second start", 1, spill_busy);
        spill_cmd   = cmd_b;
        spill_start = 1'b1;
        @(negedge clk);
        spill_start = 1'b0;
        wait_spill_done("start_busy");
        idle(6);
        compare_spill("start_busy", cmd_a);
        check_value("start_busy", "spill_busy after spill", 0, spill_busy);
    endtask

    task automatic test_back_to_back();
        scpad_pkg::spill_cmd_t cmd;
        int                    k;
        for (k = 0; k < 4; k++) begin
            cmd = make_cmd($urandom % `SCPAD_ROWS, 1 + ($urandom % 8));
            start_spill(cmd);
            wait_spill_done($sformatf("back_to_back %0d", k));
            compare_spill($sformatf("back_to_back %0d", k), cmd);
        end
        idle(4);
        check_value("back_to_back", "spill_busy at end", 0, spill_busy);
    endtask

    initial begin
        int r;
        void'($urandom(12));
        fill_en     = 1'b0;
        fill_row    = '0;
        fill_data   = '0;
        spill_start = 1'b0;
        spill_cmd   = '0;

        test_reset();
        for (r = 0; r < `SCPAD_ROWS; r++) begin
            load_row(scpad_pkg::row_idx_t'(r), random_row());
        end

        test_full_spill();
        test_partial_spill();
        test_random_stall();
        test_start_while_busy();
        test_back_to_back();
        idle(2);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
